//--- hdl/cae_settings.svh
`ifndef CAE_SETTINGS_SVH
`define CAE_SETTINGS_SVH

// ****************************************
// register file
// ****************************************

`define CAE_AEG_COUNT 2
`define CAE_AEG_IDX_W 18

// ****************************************
// processing element chain
// ****************************************

`define CAE_PE_COUNT 4
// target value seen by every stage
`define CAE_PE_BROADCAST 16

// stall floor after a launch, in cycles
`define CAE_MIN_BUSY_CYCLES 32
// watchdog fires after 2**width busy cycles
`define CAE_WATCHDOG_W 10

// ****************************************
// host instruction encodings
// ****************************************

// top byte of the instruction word
`define CAE_OPC_AEG_WR 8'h40
`define CAE_OPC_AEG_RD 8'h41
// top three bits, caep number follows
`define CAE_OPC_CUSTOM 3'b011

`endif

//--- hdl/cae_dispatch_pkg.sv
`include "cae_settings.svh"

package cae_dispatch_pkg;

   // host request, one cycle per valid
   typedef struct packed {
      logic [31:0] inst;
      logic [63:0] data;
      logic        valid;
   } dispatch_req_t;

   // decode result
   typedef struct packed {
      logic                      valid;
      logic                      aeg_wr;
      logic                      aeg_rd;
      logic                      custom;
      logic [4:0]                caep;
      logic [`CAE_AEG_IDX_W-1:0] aeg_idx;
      logic                      unimpl;
   } decoded_t;

   // read return to host
   typedef struct packed {
      logic        valid;
      logic [63:0] data;
   } ret_t;

   // exception bits, index error on top
   typedef struct packed {
      logic aeg_idx;
      logic unimpl;
   } exception_t;

endpackage

//--- hdl/pe_chain_pkg.sv
package pe_chain_pkg;

   // chain opcodes
   typedef enum logic [2:0] {
      op_nop    = 3'd0,
      op_reset  = 3'd1,
      // stay busy for delay cycles
      op_delay  = 3'd2,
      // passes through and lands in aeg 0
      op_return = 3'd3
   } pe_opcode_e;

   // 64-bit chain word, opcode in the low bits
   typedef struct packed {
      logic [39:0] arg;
      logic [15:0] delay;
      logic [4:0]  target;
      pe_opcode_e  opcode;
   } pe_inst_t;

endpackage

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

`include "cae_settings.svh"

module inst_decoder (
   input  cae_dispatch_pkg::dispatch_req_t req_i,
   output cae_dispatch_pkg::decoded_t      dec_o
);

   logic [7:0] top_byte;
   logic [2:0] top_bits;

   assign top_byte = req_i.inst[31:24];
   assign top_bits = req_i.inst[31:29];

   // ****************************************
   // instruction classes
   // ****************************************

   always_comb begin
      dec_o         = '0;
      dec_o.valid   = req_i.valid;
      dec_o.caep    = req_i.inst[28:24];
      dec_o.aeg_idx = req_i.inst[`CAE_AEG_IDX_W-1:0];

      if (req_i.valid) begin
         if (top_byte == `CAE_OPC_AEG_WR) begin
            dec_o.aeg_wr = 1'b1;
         end else if (top_byte == `CAE_OPC_AEG_RD) begin
            dec_o.aeg_rd = 1'b1;
         end else if (top_bits == `CAE_OPC_CUSTOM) begin
            dec_o.custom = 1'b1;
         end else begin
            // nothing else is implemented
            dec_o.unimpl = 1'b1;
         end
      end
   end

endmodule

//--- hdl/aeg_file.sv
`timescale 1ns/1ps

`include "cae_settings.svh"

module aeg_file (
   input  logic                             clk,
   input  logic                             reset_per,
   input  cae_dispatch_pkg::decoded_t       dec_i,
   input  logic [63:0]                      data_i,
   input  pe_chain_pkg::pe_inst_t           return_i,
   output pe_chain_pkg::pe_inst_t           aeg0_o,
   output cae_dispatch_pkg::ret_t           ret_o,
   output cae_dispatch_pkg::exception_t     exception_o
);

   localparam int SEL_W = (`CAE_AEG_COUNT > 1) ? $clog2(`CAE_AEG_COUNT) : 1;

   logic [63:0]      aeg_q [`CAE_AEG_COUNT];
   logic [SEL_W-1:0] sel;
   logic             idx_ok;
   logic             wr_en;
   logic             rd_en;
   logic             capture;
   logic             ret_valid_q;
   logic [63:0]      ret_data_q;
   logic             err_idx_q;
   logic             err_unimpl_q;

   assign sel    = dec_i.aeg_idx[SEL_W-1:0];
   assign idx_ok = dec_i.aeg_idx < `CAE_AEG_COUNT;
   assign wr_en  = dec_i.aeg_wr && idx_ok;
   assign rd_en  = dec_i.aeg_rd && idx_ok;

   // host write to aeg 0 wins over a returning word
   assign capture = (return_i.opcode == pe_chain_pkg::op_return) && !(wr_en && sel == 0);

   // ****************************************
   // registers
   // ****************************************

   always_ff @(posedge clk) begin
      for (int i = 0; i < `CAE_AEG_COUNT; i++) begin
         if (wr_en && sel == i) begin
            aeg_q[i] <= data_i;
         end
      end
      if (capture) begin
         aeg_q[0] <= return_i;
      end
   end

   assign aeg0_o = pe_chain_pkg::pe_inst_t'(aeg_q[0]);

   // read data
   always_ff @(posedge clk) begin
      if (rd_en) begin
         ret_data_q <= aeg_q[sel];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         ret_valid_q  <= 1'b0;
         err_idx_q    <= 1'b0;
         err_unimpl_q <= 1'b0;
      end else begin
         ret_valid_q  <= rd_en;
         err_idx_q    <= (dec_i.aeg_wr || dec_i.aeg_rd) && !idx_ok;
         // only caep 0..2 are known
         err_unimpl_q <= dec_i.unimpl || (dec_i.custom && dec_i.caep > 5'd2);
      end
   end

   assign ret_o.valid         = ret_valid_q;
   assign ret_o.data          = ret_data_q;
   assign exception_o.aeg_idx = err_idx_q;
   assign exception_o.unimpl  = err_unimpl_q;

   // a bad index never returns data
   a_ret_no_idx_err: assert property (
      @(posedge clk) disable iff (reset_per)
      !(ret_o.valid && exception_o.aeg_idx)
   );

endmodule

//--- hdl/launch_ctrl.sv
`timescale 1ns/1ps

`include "cae_settings.svh"

module launch_ctrl (
   input  logic                       clk,
   input  logic                       reset_per,
   input  cae_dispatch_pkg::decoded_t dec_i,
   input  pe_chain_pkg::pe_inst_t     aeg0_i,
   input  logic                       chain_busy_i,
   output pe_chain_pkg::pe_inst_t     inst_o,
   output logic                       stall_o,
   output logic                       idle_o
);

   localparam int MIN_W = $clog2(`CAE_MIN_BUSY_CYCLES + 1);

   logic                         launch;
   logic                         send_q;
   logic [MIN_W-1:0]             min_cnt_q;
   logic [`CAE_WATCHDOG_W-1:0]   wd_cnt_q;
   logic                         wd_fire;
   pe_chain_pkg::pe_inst_t       reset_word;
   pe_chain_pkg::pe_inst_t       inst_q;

   // caep 1 starts the chain
   assign launch = dec_i.custom && dec_i.caep == 5'd1;

   always_ff @(posedge clk) begin
      if (reset_per) begin
         send_q <= 1'b0;
      end else begin
         send_q <= launch;
      end
   end

   // ****************************************
   // busy floor and watchdog
   // ****************************************

   always_ff @(posedge clk) begin
      if (reset_per) begin
         min_cnt_q <= '0;
      end else if (send_q) begin
         min_cnt_q <= MIN_W'(`CAE_MIN_BUSY_CYCLES);
      end else if (min_cnt_q != 0) begin
         min_cnt_q <= min_cnt_q - 1'b1;
      end
   end

   assign stall_o = launch || send_q || (min_cnt_q != 0) || chain_busy_i;
   assign idle_o  = !stall_o;

   // wraps to zero as it fires
   always_ff @(posedge clk) begin
      if (reset_per || !stall_o) begin
         wd_cnt_q <= '0;
      end else begin
         wd_cnt_q <= wd_cnt_q + 1'b1;
      end
   end

   assign wd_fire = stall_o && (&wd_cnt_q);

   // ****************************************
   // chain word
   // ****************************************

   always_comb begin
      reset_word        = '0;
      reset_word.target = 5'(`CAE_PE_BROADCAST);
      reset_word.opcode = pe_chain_pkg::op_reset;
   end

   always_ff @(posedge clk) begin
      if (reset_per || wd_fire) begin
         inst_q <= reset_word;
      end else if (send_q) begin
         inst_q <= aeg0_i;
      end else begin
         inst_q <= '0;
      end
   end

   assign inst_o = inst_q;

   a_stall_idle: assert property (
      @(posedge clk) disable iff (reset_per)
      stall_o != idle_o
   );

endmodule

//--- hdl/pe_stage.sv
`timescale 1ns/1ps

`include "cae_settings.svh"

module pe_stage #(
   parameter int PE_ID = 0
) (
   input  logic                   clk,
   input  logic                   reset_per,
   input  pe_chain_pkg::pe_inst_t inst_i,
   output pe_chain_pkg::pe_inst_t inst_o,
   input  logic                   busy_i,
   output logic                   busy_o
);

   pe_chain_pkg::pe_inst_t inst_q;
   logic [15:0]            cnt_q;
   logic                   addressed;
   logic                   load;
   logic                   clear;

   // forward every word one stage per cycle
   always_ff @(posedge clk) begin
      inst_q <= inst_i;
   end

   assign inst_o = inst_q;

   // ****************************************
   // delay counter
   // ****************************************

   assign addressed = (inst_i.target == 5'(PE_ID)) ||
                      (inst_i.target == 5'(`CAE_PE_BROADCAST));
   assign load      = addressed && inst_i.opcode == pe_chain_pkg::op_delay;
   assign clear     = addressed && inst_i.opcode == pe_chain_pkg::op_reset;

   always_ff @(posedge clk) begin
      if (reset_per || clear) begin
         cnt_q <= '0;
      end else if (load) begin
         cnt_q <= inst_i.delay;
      end else if (cnt_q != 0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // busy accumulates towards the end of the chain
   assign busy_o = busy_i || (cnt_q != 0);

   a_load_clear: assert property (
      @(posedge clk) disable iff (reset_per)
      !(load && clear)
   );

endmodule

//--- hdl/cae_pers.sv
`timescale 1ns/1ps

`include "cae_settings.svh"

module cae_pers (
   input  logic                             clk,
   input  logic                             reset_per,
   input  cae_dispatch_pkg::dispatch_req_t  req_i,
   output cae_dispatch_pkg::ret_t           ret_o,
   output cae_dispatch_pkg::exception_t     exception_o,
   output logic                             stall_o,
   output logic                             idle_o
);

   cae_dispatch_pkg::decoded_t dec;
   pe_chain_pkg::pe_inst_t     aeg0;
   pe_chain_pkg::pe_inst_t     chain_inst [`CAE_PE_COUNT+1];
   logic [`CAE_PE_COUNT:0]     chain_busy;

   // ****************************************
   // dispatch side
   // ****************************************

   inst_decoder inst_decoder_i (
      .req_i (req_i),
      .dec_o (dec)
   );

   aeg_file aeg_file_i (
      .clk         (clk),
      .reset_per   (reset_per),
      .dec_i       (dec),
      .data_i      (req_i.data),
      .return_i    (chain_inst[`CAE_PE_COUNT]),
      .aeg0_o      (aeg0),
      .ret_o       (ret_o),
      .exception_o (exception_o)
   );

   launch_ctrl launch_ctrl_i (
      .clk          (clk),
      .reset_per    (reset_per),
      .dec_i        (dec),
      .aeg0_i       (aeg0),
      .chain_busy_i (chain_busy[`CAE_PE_COUNT]),
      .inst_o       (chain_inst[0]),
      .stall_o      (stall_o),
      .idle_o       (idle_o)
   );

   // ****************************************
   // pe chain
   // ****************************************

   // nothing ahead of the first stage
   assign chain_busy[0] = 1'b0;

   for (genvar g = 0; g < `CAE_PE_COUNT; g++) begin : gen_pe
      pe_stage #(
         .PE_ID (g)
      ) pe_stage_i (
         .clk       (clk),
         .reset_per (reset_per),
         .inst_i    (chain_inst[g]),
         .inst_o    (chain_inst[g+1]),
         .busy_i    (chain_busy[g]),
         .busy_o    (chain_busy[g+1])
      );
   end

endmodule

//--- verification/cae_pers_tb.sv
`timescale 1ns/1ps

`include "cae_settings.svh"

module cae_pers_tb;

   localparam int SEED          = 9914;
   localparam int SHORT_DELAY   = 300;
   localparam int LONG_DELAY    = 3000;
   localparam int WD_LIMIT      = 2 ** `CAE_WATCHDOG_W;
   // writes, reads and the short launches fit well inside this
   localparam int SETUP_CYCLES  = 700;
   localparam int WATCHDOG_CYCLES = 5 * (LONG_DELAY + SHORT_DELAY + SETUP_CYCLES);

   logic                            clk;
   logic                            reset_per;
   cae_dispatch_pkg::dispatch_req_t req;
   cae_dispatch_pkg::ret_t          ret_o;
   cae_dispatch_pkg::exception_t    exception_o;
   logic                            stall_o;
   logic                            idle_o;

   logic [63:0] aeg_model [`CAE_AEG_COUNT];
   int          value_errs;
   int          other_errs;

   cae_pers cae_pers_i (
      .clk         (clk),
      .reset_per   (reset_per),
      .req_i       (req),
      .ret_o       (ret_o),
      .exception_o (exception_o),
      .stall_o     (stall_o),
      .idle_o      (idle_o)
   );

   always #20 clk = ~clk;

   // ****************************************
   // instruction and result builders
   // ****************************************

   function automatic logic [31:0] wr_inst(input int idx);
      return {`CAE_OPC_AEG_WR, 6'd0, idx[`CAE_AEG_IDX_W-1:0]};
   endfunction

   function automatic logic [31:0] rd_inst(input int idx);
      return {`CAE_OPC_AEG_RD, 6'd0, idx[`CAE_AEG_IDX_W-1:0]};
   endfunction

   function automatic logic [31:0] custom_inst(input logic [4:0] caep);
      return {`CAE_OPC_CUSTOM, caep, 24'd0};
   endfunction

   function automatic cae_dispatch_pkg::ret_t ret_of(input logic valid, input logic [63:0] data);
      cae_dispatch_pkg::ret_t r;
      r.valid = valid;
      r.data  = data;
      return r;
   endfunction

   function automatic cae_dispatch_pkg::exception_t exc_of(input logic idx_err,
                                                           input logic unimpl_err);
      cae_dispatch_pkg::exception_t e;
      e.aeg_idx = idx_err;
      e.unimpl  = unimpl_err;
      return e;
   endfunction

   // ****************************************
   // compare tasks
   // ****************************************

   task automatic check_ret(input string name, input cae_dispatch_pkg::ret_t got,
                            input cae_dispatch_pkg::ret_t exp);
      if (got.valid !== exp.valid) begin
         value_errs++;
         $display("FAILED at %0t: %s.valid got %b expected %b",
                  $time, name, got.valid, exp.valid);
      end else if (exp.valid && got.data !== exp.data) begin
         value_errs++;
         $display("FAILED at %0t: %s.data got %h expected %h",
                  $time, name, got.data, exp.data);
      end
   endtask

   task automatic check_exception(input string name, input cae_dispatch_pkg::exception_t got,
                                  input cae_dispatch_pkg::exception_t exp);
      if (got !== exp) begin
         value_errs++;
         $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errs++;
         $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // ****************************************
   // drivers
   // ****************************************

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // one request and its result in the following cycle only
   task automatic host_op(input logic [31:0] inst, input logic [63:0] data,
                          input cae_dispatch_pkg::ret_t exp_ret,
                          input cae_dispatch_pkg::exception_t exp_exc);
      next_cycle();
      req.inst  = inst;
      req.data  = data;
      req.valid = 1'b1;
      @(negedge clk);
      check_ret("ret_o", ret_o, ret_of(1'b0, '0));
      check_exception("exception_o", exception_o, exc_of(1'b0, 1'b0));
      check_flag("stall_o", stall_o, 1'b0);
      next_cycle();
      req.valid = 1'b0;
      @(negedge clk);
      check_ret("ret_o", ret_o, exp_ret);
      check_exception("exception_o", exception_o, exp_exc);
      @(negedge clk);
      check_ret("ret_o", ret_o, ret_of(1'b0, '0));
      check_exception("exception_o", exception_o, exc_of(1'b0, 1'b0));
   endtask

   // counts stall cycles after the cycle that follows the launch
   task automatic launch_chain(input int limit, input logic overwrite,
                               input logic [63:0] new_aeg0, output int stall_cycles);
      stall_cycles = 0;
      next_cycle();
      req.inst  = custom_inst(5'd1);
      req.data  = '0;
      req.valid = 1'b1;
      @(negedge clk);
      check_flag("stall_o", stall_o, 1'b1);
      check_flag("idle_o", idle_o, 1'b0);
      next_cycle();
      req.valid = 1'b0;
      @(negedge clk);
      check_flag("stall_o", stall_o, 1'b1);
      // the word has left aeg 0 and is in the chain now
      next_cycle();
      req.inst  = wr_inst(0);
      req.data  = new_aeg0;
      req.valid = overwrite;
      @(negedge clk);
      while (stall_o && stall_cycles < limit) begin
         check_flag("idle_o", idle_o, 1'b0);
         stall_cycles++;
         next_cycle();
         req.valid = 1'b0;
         @(negedge clk);
      end
      if (stall_o) begin
         other_errs++;
         $display("stall_o still high after %0d cycles of waiting", limit);
      end else begin
         check_flag("idle_o", idle_o, 1'b1);
      end
   endtask

   // ****************************************
   // directed tests
   // ****************************************

   task automatic write_read_test();
      logic [63:0] val;
      for (int i = 0; i < `CAE_AEG_COUNT; i++) begin
         val = {$urandom, $urandom};
         host_op(wr_inst(i), val, ret_of(1'b0, '0), exc_of(1'b0, 1'b0));
         aeg_model[i] = val;
      end
      for (int i = 0; i < `CAE_AEG_COUNT; i++) begin
         host_op(rd_inst(i), '0, ret_of(1'b1, aeg_model[i]), exc_of(1'b0, 1'b0));
      end
   endtask

   task automatic exception_test();
      host_op(wr_inst(2), {$urandom, $urandom}, ret_of(1'b0, '0), exc_of(1'b1, 1'b0));
      host_op(rd_inst(2), '0, ret_of(1'b0, '0), exc_of(1'b1, 1'b0));
      host_op(rd_inst(18'h3ffff), '0, ret_of(1'b0, '0), exc_of(1'b1, 1'b0));
      host_op(32'h1234_5678, '0, ret_of(1'b0, '0), exc_of(1'b0, 1'b1));
      host_op(custom_inst(5'd5), '0, ret_of(1'b0, '0), exc_of(1'b0, 1'b1));
      // accepted and ignored
      host_op(custom_inst(5'd0), '0, ret_of(1'b0, '0), exc_of(1'b0, 1'b0));
      host_op(custom_inst(5'd2), '0, ret_of(1'b0, '0), exc_of(1'b0, 1'b0));
      for (int i = 0; i < `CAE_AEG_COUNT; i++) begin
         host_op(rd_inst(i), '0, ret_of(1'b1, aeg_model[i]), exc_of(1'b0, 1'b0));
      end
   endtask

   task automatic return_test();
      pe_chain_pkg::pe_inst_t word;
      logic [63:0]            rnd;
      logic [63:0]            other;
      int                     cycles;
      rnd         = {$urandom, $urandom};
      word.arg    = rnd[39:0];
      word.delay  = rnd[55:40];
      word.target = rnd[60:56];
      word.opcode = pe_chain_pkg::op_return;
      other       = ~word;
      host_op(wr_inst(0), word, ret_of(1'b0, '0), exc_of(1'b0, 1'b0));
      aeg_model[0] = word;
      // the returning word lands on top of the overwrite
      launch_chain(200, 1'b1, other, cycles);
      if (cycles < `CAE_MIN_BUSY_CYCLES) begin
         other_errs++;
         $display("stall after a return launch lasted only %0d cycles", cycles);
      end
      host_op(rd_inst(0), '0, ret_of(1'b1, aeg_model[0]), exc_of(1'b0, 1'b0));
   endtask

   task automatic delay_test();
      pe_chain_pkg::pe_inst_t word;
      logic [63:0]            other;
      int                     cycles;
      word.arg    = {$urandom, 8'h00};
      word.delay  = 16'(SHORT_DELAY);
      word.target = 5'd2;
      word.opcode = pe_chain_pkg::op_delay;
      other       = ~word;
      host_op(wr_inst(0), word, ret_of(1'b0, '0), exc_of(1'b0, 1'b0));
      launch_chain(1000, 1'b1, other, cycles);
      aeg_model[0] = other;
      if (cycles < SHORT_DELAY || cycles >= WD_LIMIT) begin
         other_errs++;
         $display("stall for a delay of %0d lasted %0d cycles", SHORT_DELAY, cycles);
      end
      // a delay word is not captured on its way out
      host_op(rd_inst(0), '0, ret_of(1'b1, aeg_model[0]), exc_of(1'b0, 1'b0));
   endtask

   task automatic watchdog_test();
      pe_chain_pkg::pe_inst_t word;
      int                     cycles;
      word.arg    = '0;
      word.delay  = 16'(LONG_DELAY);
      word.target = 5'(`CAE_PE_BROADCAST);
      word.opcode = pe_chain_pkg::op_delay;
      host_op(wr_inst(0), word, ret_of(1'b0, '0), exc_of(1'b0, 1'b0));
      aeg_model[0] = word;
      launch_chain(LONG_DELAY + 1000, 1'b0, '0, cycles);
      // two launch cycles come before the counted ones
      if (cycles + 2 <= WD_LIMIT || cycles + 2 >= LONG_DELAY) begin
         other_errs++;
         $display("watchdog did not end a %0d cycle delay, stall lasted %0d cycles",
                  LONG_DELAY, cycles + 2);
      end
      // cleared counters keep the chain quiet
      repeat (50) begin
         @(negedge clk);
         check_flag("stall_o", stall_o, 1'b0);
      end
      host_op(rd_inst(0), '0, ret_of(1'b1, aeg_model[0]), exc_of(1'b0, 1'b0));
   endtask

   // ****************************************
   // main sequence
   // ****************************************

   initial begin
      void'($urandom(SEED));
      clk        = 1'b0;
      reset_per  = 1'b1;
      req        = '0;
      value_errs = 0;
      other_errs = 0;
      repeat (5) @(posedge clk);
      #2;
      reset_per = 1'b0;
      @(negedge clk);
      check_ret("ret_o", ret_o, ret_of(1'b0, '0));
      check_exception("exception_o", exception_o, exc_of(1'b0, 1'b0));
      check_flag("stall_o", stall_o, 1'b0);
      check_flag("idle_o", idle_o, 1'b1);

      write_read_test();
      exception_test();
      return_test();
      delay_test();
      watchdog_test();

      $display("errors: %0d value, %0d other", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      other_errs++;
      $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("errors: %0d value, %0d other", value_errs, other_errs);
      $display("Regression failed");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+hdl
hdl/cae_dispatch_pkg.sv
hdl/pe_chain_pkg.sv
hdl/inst_decoder.sv
hdl/aeg_file.sv
hdl/launch_ctrl.sv
hdl/pe_stage.sv
hdl/cae_pers.sv
verification/cae_pers_tb.sv
